// File: project.f
logic/game_geom_pkg.sv
logic/motion_pkg.sv
logic/motion_cfg_regs.sv
logic/platform_collide.sv
logic/host_move_ctrl.sv
logic/host_motion_top.sv
bench/tb_clk_gen.sv
bench/tb_host_motion.sv

// File: Bender.yml
package:
  name: host_motion

sources:
  - logic/game_geom_pkg.sv
  - logic/motion_pkg.sv
  - logic/motion_cfg_regs.sv
  - logic/platform_collide.sv
  - logic/host_move_ctrl.sv
  - logic/host_motion_top.sv
  - target: simulation
    files:
      - bench/tb_clk_gen.sv
      - bench/tb_host_motion.sv

// File: bench/tb_host_motion.sv
// directed tests with small periods written over the config port; host must start each test idle
`timescale 1ns/1ns

module tb_host_motion;

    localparam int RST_TIMEOUT  = 50;
    localparam int IDLE_TIMEOUT = 200;
    localparam int WALK_TIMEOUT = 20000;
    localparam int JUMP_TIMEOUT = 5000;

    logic                     clk;
    logic                     rst;
    logic                     restart;
    logic [1:0]               over;
    logic                     left;
    logic                     right;
    logic                     jump;
    logic                     cfg_we;
    motion_pkg::cfg_addr_t    cfg_addr;
    motion_pkg::period_t      cfg_wdata;
    game_geom_pkg::coord_t    host_x;
    game_geom_pkg::coord_t    host_y;
    motion_pkg::sprite_ctrl_t sprite_ctrl;

    motion_pkg::period_t      walk_per;
    motion_pkg::period_t      air_per;
    game_geom_pkg::coord_t    jump_h;
    logic [31:0]              rng_state = 32'had76_0ad4;

    tb_clk_gen u_clk (.clk(clk), .rst(rst));

    host_motion_top u_dut (
        .clk(clk), .rst(rst), .restart(restart), .over(over),
        .left(left), .right(right), .jump(jump),
        .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
        .host_x(host_x), .host_y(host_y), .sprite_ctrl(sprite_ctrl)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // {facing right, airborne, idle, frame}
    function automatic motion_pkg::sprite_ctrl_t sprite_word(input logic face, input logic air,
                                                             input logic idle,
                                                             input logic [2:0] frame);
        return {face, air, idle, 1'b0, frame};
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_coord(input string test, input game_geom_pkg::coord_t exp,
                               input game_geom_pkg::coord_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("ERR %s expected %0d actual %0d", test, exp, act));
        end
    endtask

    task automatic check_sprite(input string test, input motion_pkg::sprite_ctrl_t exp,
                                input motion_pkg::sprite_ctrl_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("ERR %s expected %07b actual %07b", test, exp, act));
        end
    endtask

    task automatic write_cfg(input motion_pkg::cfg_addr_t addr, input motion_pkg::period_t data);
        @(posedge clk);
        cfg_we    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clk);
        cfg_we <= 1'b0;
    endtask

    task automatic setup_periods();
        rng_state = xorshift32(rng_state);
        walk_per  = motion_pkg::period_t'(rng_state[2:0]);
        rng_state = xorshift32(rng_state);
        air_per   = motion_pkg::period_t'(rng_state[2:0]);
        jump_h    = 10'd40;
        write_cfg(motion_pkg::CFG_WALK, walk_per);
        write_cfg(motion_pkg::CFG_AIR, air_per);
        write_cfg(motion_pkg::CFG_JUMP, 20'd2);
        write_cfg(motion_pkg::CFG_FALL, 20'd2);
        write_cfg(motion_pkg::CFG_GRAV, 20'd0);
        write_cfg(motion_pkg::CFG_JUMP_H, motion_pkg::period_t'(jump_h));
    endtask

    task automatic wait_idle(input string test);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!sprite_ctrl[4]) begin
            @(negedge clk);
            cycles++;
            if (cycles > IDLE_TIMEOUT) begin
                stop_on_error($sformatf("%s: host never came back to idle", test));
            end
        end
    endtask

    // may overshoot by one pixel when the period is 0
    task automatic walk_until(input string test, input logic to_right,
                              input game_geom_pkg::coord_t target);
        int   cycles;
        logic reached;
        cycles  = 0;
        reached = 1'b0;
        @(posedge clk);
        right <= to_right;
        left  <= !to_right;
        while (!reached) begin
            @(negedge clk);
            cycles++;
            reached = to_right ? (host_x >= target) : (host_x <= target);
            if (!reached && cycles > WALK_TIMEOUT) begin
                stop_on_error($sformatf("%s: host did not reach x=%0d in time", test, target));
            end
        end
        @(posedge clk);
        right <= 1'b0;
        left  <= 1'b0;
    endtask

    task automatic return_to_spawn(input string test);
        @(posedge clk);
        left  <= 1'b0;
        right <= 1'b0;
        jump  <= 1'b0;
        wait_idle(test);
        @(posedge clk);
        restart <= 1'b1;
        @(posedge clk);
        restart <= 1'b0;
        @(negedge clk);
        check_coord(test, game_geom_pkg::SPAWN_X, host_x);
        check_coord(test, game_geom_pkg::SPAWN_Y, host_y);
    endtask

    // y only decreases and then only increases until the host lands on the floor
    task automatic run_jump(input string test, input motion_pkg::sprite_ctrl_t air_word,
                            output game_geom_pkg::coord_t min_y);
        game_geom_pkg::coord_t prev_y;
        logic                  went_up;
        logic                  went_down;
        logic                  landed;
        int                    cycles;
        went_up   = 1'b0;
        went_down = 1'b0;
        landed    = 1'b0;
        cycles    = 0;
        @(negedge clk);
        prev_y = host_y;
        min_y  = host_y;
        @(posedge clk);
        jump <= 1'b1;
        @(posedge clk);
        jump <= 1'b0;
        while (!landed) begin
            @(negedge clk);
            cycles++;
            if (host_y < prev_y) begin
                if (went_down) begin
                    stop_on_error($sformatf("%s: host rose again while coming down", test));
                end
                went_up = 1'b1;
            end else if (host_y > prev_y) begin
                if (!went_up) begin
                    stop_on_error($sformatf("%s: host dropped before it rose", test));
                end
                went_down = 1'b1;
            end
            if (host_y != prev_y) begin
                check_sprite(test, air_word, sprite_ctrl);   // airborne on every vertical step
            end
            if (host_y < min_y) begin
                min_y = host_y;
            end
            prev_y = host_y;
            landed = went_down && sprite_ctrl[4] && !sprite_ctrl[5];
            if (!landed && cycles > JUMP_TIMEOUT) begin
                stop_on_error($sformatf("%s: host did not land in time", test));
            end
        end
        check_coord(test, game_geom_pkg::SPAWN_Y, host_y);
    endtask

    task automatic reset_state();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (rst) begin
            @(negedge clk);
            cycles++;
            if (cycles > RST_TIMEOUT) begin
                stop_on_error("reset_state: reset never released");
            end
        end
        check_coord("reset_state", game_geom_pkg::SPAWN_X, host_x);
        check_coord("reset_state", game_geom_pkg::SPAWN_Y, host_y);
        check_sprite("reset_state", sprite_word(1'b1, 1'b0, 1'b1, 3'd0), sprite_ctrl);
    endtask

    task automatic walk_steps();
        game_geom_pkg::coord_t x0;
        setup_periods();
        @(negedge clk);
        x0 = host_x;
        @(posedge clk);
        right <= 1'b1;
        repeat (16 * (walk_per + 1)) @(posedge clk);   // 16 pixels exactly
        right <= 1'b0;
        @(negedge clk);
        check_coord("walk_steps", x0 + 10'd16, host_x);
        check_sprite("walk_steps", sprite_word(1'b1, 1'b0, 1'b0, 3'd2), sprite_ctrl);
        wait_idle("walk_steps");
        check_coord("walk_steps", x0 + 10'd16, host_x);
        @(posedge clk);
        left <= 1'b1;
        repeat (16 * (walk_per + 1)) @(posedge clk);
        left <= 1'b0;
        @(negedge clk);
        check_coord("walk_steps", x0, host_x);
        check_sprite("walk_steps", sprite_word(1'b0, 1'b0, 1'b0, 3'd4), sprite_ctrl);
        return_to_spawn("walk_steps");
    endtask

    task automatic edge_clamp();
        setup_periods();
        write_cfg(motion_pkg::CFG_WALK, 20'd0);
        @(posedge clk);
        left <= 1'b1;
        repeat (int'(game_geom_pkg::SPAWN_X) + 50) @(negedge clk);
        check_coord("edge_clamp", 10'd0, host_x);
        repeat (20) begin
            @(negedge clk);
            check_coord("edge_clamp", 10'd0, host_x);
        end
        // one frame per 8 ground pixels
        check_sprite("edge_clamp",
                     sprite_word(1'b0, 1'b0, 1'b0, 3'((game_geom_pkg::SPAWN_X / 8) % 8)),
                     sprite_ctrl);
        return_to_spawn("edge_clamp");
    endtask

    task automatic jump_arc();
        game_geom_pkg::coord_t min_y;
        game_geom_pkg::coord_t low_bound;
        setup_periods();
        low_bound = game_geom_pkg::SPAWN_Y - jump_h - 10'd1;
        run_jump("jump_arc", sprite_word(1'b1, 1'b1, 1'b0, 3'd0), min_y);
        if (min_y < low_bound) begin
            check_coord("jump_arc", low_bound, min_y);
        end
        check_coord("jump_arc", game_geom_pkg::SPAWN_X, host_x);
        check_sprite("jump_arc", sprite_word(1'b1, 1'b0, 1'b1, 3'd0), sprite_ctrl);
        return_to_spawn("jump_arc");
    endtask

    task automatic restart_spawn();
        setup_periods();
        walk_until("restart_spawn", 1'b1, game_geom_pkg::SPAWN_X + 10'd12);
        wait_idle("restart_spawn");
        @(posedge clk);
        restart <= 1'b1;
        @(posedge clk);
        repeat (4) begin
            @(negedge clk);
            check_coord("restart_spawn", game_geom_pkg::SPAWN_X, host_x);
            check_coord("restart_spawn", game_geom_pkg::SPAWN_Y, host_y);
            check_sprite("restart_spawn", sprite_word(1'b1, 1'b0, 1'b1, 3'd0), sprite_ctrl);
        end
        @(posedge clk);
        restart <= 1'b0;
        // leave facing left so the reset word differs
        walk_until("restart_spawn", 1'b0, game_geom_pkg::SPAWN_X - 10'd12);
        wait_idle("restart_spawn");
        @(posedge clk);
        over <= 2'd1;
        @(posedge clk);
        repeat (4) begin
            @(negedge clk);
            check_coord("restart_spawn", game_geom_pkg::SPAWN_X, host_x);
            check_coord("restart_spawn", game_geom_pkg::SPAWN_Y, host_y);
            check_sprite("restart_spawn", sprite_word(1'b1, 1'b0, 1'b1, 3'd0), sprite_ctrl);
        end
        @(posedge clk);
        over <= 2'd0;
        return_to_spawn("restart_spawn");
    endtask

    task automatic platform_landing();
        game_geom_pkg::coord_t    min_y;
        game_geom_pkg::coord_t    apex;
        game_geom_pkg::coord_t    col;
        game_geom_pkg::coord_t    reach;
        logic                     under;
        motion_pkg::sprite_ctrl_t air_word;
        setup_periods();
        // high enough for the feet to pass the platform top
        jump_h = game_geom_pkg::coord_t'(int'(game_geom_pkg::SPAWN_Y) -
                 int'(game_geom_pkg::PLAT_Y[0]) + game_geom_pkg::HOST_H + 8);
        write_cfg(motion_pkg::CFG_JUMP_H, motion_pkg::period_t'(jump_h));
        walk_until("platform_landing", 1'b0, game_geom_pkg::PLAT_X0[0] + 10'd40);
        wait_idle("platform_landing");
        col   = host_x;
        under = (col <= game_geom_pkg::PLAT_X1[0]) &&
                (int'(col) + game_geom_pkg::HOST_W - 1 >= int'(game_geom_pkg::PLAT_X0[0]));
        reach = game_geom_pkg::SPAWN_Y - game_geom_pkg::PLAT_Y[0] - 10'd1;
        if (under && jump_h >= reach) begin
            apex = game_geom_pkg::PLAT_Y[0] + 10'd1;   // head stops one row under the platform
        end else begin
            apex = game_geom_pkg::SPAWN_Y - jump_h - 10'd1;
        end
        // walked left from spawn with the frame counter cleared
        air_word = sprite_word(1'b0, 1'b1, 1'b0,
                               3'((int'(game_geom_pkg::SPAWN_X) - int'(col)) / 8 % 8));
        run_jump("platform_landing", air_word, min_y);
        check_coord("platform_landing", apex, min_y);
        check_coord("platform_landing", col, host_x);
        return_to_spawn("platform_landing");
    endtask

    initial begin
        restart   = 1'b0;
        over      = 2'd0;
        left      = 1'b0;
        right     = 1'b0;
        jump      = 1'b0;
        cfg_we    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        reset_state();
        walk_steps();
        edge_clamp();
        jump_arc();
        restart_spawn();
        platform_landing();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: bench/tb_clk_gen.sv
// free-running 10 ns clock; rst held high for the first 4 rising edges
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    localparam int RST_CYCLES = 4;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;   // released on an edge like any other input
    end

endmodule

// File: logic/host_motion_top.sv
// configuration writes are plain strobes with no handshake; over is a level from the game logic
`timescale 1ns/1ns

module host_motion_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     restart,
    input  logic [1:0]               over,
    input  logic                     left,
    input  logic                     right,
    input  logic                     jump,
    input  logic                     cfg_we,
    input  motion_pkg::cfg_addr_t    cfg_addr,
    input  motion_pkg::period_t      cfg_wdata,
    output game_geom_pkg::coord_t    host_x,
    output game_geom_pkg::coord_t    host_y,
    output motion_pkg::sprite_ctrl_t sprite_ctrl
);

    motion_pkg::period_t   walk_period, air_period, jump_period, fall_period, grav_step;
    game_geom_pkg::coord_t jump_height;
    game_geom_pkg::coord_t cand_x, cand_y;
    logic                  on_ground, head_hit;

    motion_cfg_regs u_cfg (
        .clk(clk), .rst(rst), .we(cfg_we), .addr(cfg_addr), .wdata(cfg_wdata),
        .walk_period(walk_period), .air_period(air_period), .jump_period(jump_period),
        .fall_period(fall_period), .grav_step(grav_step), .jump_height(jump_height)
    );

    platform_collide u_collide (
        .cand_x(cand_x), .cand_y(cand_y), .on_ground(on_ground), .head_hit(head_hit)
    );

    host_move_ctrl u_ctrl (
        .clk(clk), .rst(rst), .restart(restart), .over(over),
        .left(left), .right(right), .jump(jump),
        .walk_period(walk_period), .air_period(air_period), .jump_period(jump_period),
        .fall_period(fall_period), .grav_step(grav_step), .jump_height(jump_height),
        .on_ground(on_ground), .head_hit(head_hit),
        .cand_x(cand_x), .cand_y(cand_y),
        .host_x(host_x), .host_y(host_y), .sprite_ctrl(sprite_ctrl)
    );

endmodule

// File: logic/host_move_ctrl.sv
// one pixel per period+1 cycles per axis; only restart and over in IDLE send the host to spawn
`timescale 1ns/1ns

module host_move_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       restart,
    input  logic [1:0]                 over,
    input  logic                       left,
    input  logic                       right,
    input  logic                       jump,

    input  motion_pkg::period_t        walk_period,
    input  motion_pkg::period_t        air_period,
    input  motion_pkg::period_t        jump_period,
    input  motion_pkg::period_t        fall_period,
    input  motion_pkg::period_t        grav_step,
    input  game_geom_pkg::coord_t      jump_height,

    input  logic                       on_ground,
    input  logic                       head_hit,

    output game_geom_pkg::coord_t      cand_x,
    output game_geom_pkg::coord_t      cand_y,
    output game_geom_pkg::coord_t      host_x,
    output game_geom_pkg::coord_t      host_y,
    output motion_pkg::sprite_ctrl_t   sprite_ctrl
);

    localparam game_geom_pkg::coord_t X_MAX =
        game_geom_pkg::coord_t'(game_geom_pkg::SCREEN_W - game_geom_pkg::HOST_W);
    localparam logic [10:0] SLOW_ZONE = 11'd25;   // pixels below the apex where rise slows

    motion_pkg::move_state_t  state, state_nxt;
    game_geom_pkg::coord_t    x_nxt, y_nxt;
    game_geom_pkg::coord_t    jump_y0, jump_y0_nxt;   // row the jump took off from
    game_geom_pkg::coord_t    rise;
    motion_pkg::period_t      cnt_x, cnt_x_nxt;
    motion_pkg::period_t      cnt_y, cnt_y_nxt;
    motion_pkg::period_t      jump_per, jump_per_nxt;
    motion_pkg::period_t      fall_per, fall_per_nxt;
    motion_pkg::period_t      x_per;
    logic [2:0]               px_cnt, px_cnt_nxt;     // ground pixels since last frame step
    logic [2:0]               frame_nxt;
    logic                     face_nxt;
    logic                     go_left, go_right;
    logic                     airborne, x_moved;
    logic [20:0]              jump_sum, fall_floor;
    motion_pkg::sprite_ctrl_t sprite_nxt;

    // collision is always judged on the current position
    assign cand_x = host_x;
    assign cand_y = host_y;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= motion_pkg::IDLE;
            host_x      <= game_geom_pkg::SPAWN_X;
            host_y      <= game_geom_pkg::SPAWN_Y;
            jump_y0     <= game_geom_pkg::SPAWN_Y;
            cnt_x       <= '0;
            cnt_y       <= '0;
            jump_per    <= '0;
            fall_per    <= '0;
            px_cnt      <= '0;
            sprite_ctrl <= motion_pkg::SPRITE_RESET;
        end else begin
            state       <= state_nxt;
            host_x      <= x_nxt;
            host_y      <= y_nxt;
            jump_y0     <= jump_y0_nxt;
            cnt_x       <= cnt_x_nxt;
            cnt_y       <= cnt_y_nxt;
            jump_per    <= jump_per_nxt;
            fall_per    <= fall_per_nxt;
            px_cnt      <= px_cnt_nxt;
            sprite_ctrl <= sprite_nxt;
        end
    end

    always_comb begin
        go_right   = right && !left;
        go_left    = left && !right;
        airborne   = (state == motion_pkg::JUMPING) || (state == motion_pkg::FALLING);
        x_per      = airborne ? air_period : walk_period;
        rise       = jump_y0 - host_y;
        jump_sum   = {1'b0, jump_per} + {1'b0, grav_step};
        fall_floor = {1'b0, motion_pkg::FALL_MIN_PERIOD} + {1'b0, grav_step};

        state_nxt    = state;
        x_nxt        = host_x;
        y_nxt        = host_y;
        jump_y0_nxt  = jump_y0;
        cnt_x_nxt    = '0;   // idles at zero with no single direction held
        cnt_y_nxt    = cnt_y;
        jump_per_nxt = jump_per;
        fall_per_nxt = fall_per;
        px_cnt_nxt   = px_cnt;
        x_moved      = 1'b0;
        face_nxt     = sprite_ctrl[6];
        frame_nxt    = sprite_ctrl[2:0];

        // horizontal walk, same in every state apart from the period
        if (go_right || go_left) begin
            face_nxt = go_right;
            if (cnt_x >= x_per) begin
                if (go_right && host_x < X_MAX) begin
                    x_nxt   = host_x + 10'd1;
                    x_moved = 1'b1;
                end else if (go_left && host_x != '0) begin
                    x_nxt   = host_x - 10'd1;
                    x_moved = 1'b1;
                end
            end else begin
                cnt_x_nxt = cnt_x + 20'd1;
            end
        end

        if (x_moved) begin
            if (airborne) begin
                frame_nxt = sprite_ctrl[2:0] + 3'd1;   // every pixel in the air
            end else begin
                px_cnt_nxt = px_cnt + 3'd1;
                if (px_cnt == 3'd7) begin
                    frame_nxt = sprite_ctrl[2:0] + 3'd1;
                end
            end
        end

        case (state)
            motion_pkg::IDLE, motion_pkg::MOVING: begin
                jump_y0_nxt  = host_y;
                cnt_y_nxt    = '0;
                jump_per_nxt = jump_period;
                fall_per_nxt = fall_period;
                if (state == motion_pkg::MOVING && !on_ground) begin
                    state_nxt = motion_pkg::FALLING;   // walked off an edge
                end else if (jump) begin
                    state_nxt = motion_pkg::JUMPING;
                end else if (go_right || go_left) begin
                    state_nxt = motion_pkg::MOVING;
                end else begin
                    state_nxt = motion_pkg::IDLE;
                end
            end

            motion_pkg::JUMPING: begin
                fall_per_nxt = fall_period;
                if (rise > jump_height || head_hit || host_y == '0) begin
                    state_nxt = motion_pkg::FALLING;
                    cnt_y_nxt = '0;
                end else if (cnt_y >= jump_per) begin
                    y_nxt     = host_y - 10'd1;
                    cnt_y_nxt = '0;
                    // slow down near the apex
                    if ({1'b0, rise} + SLOW_ZONE >= {1'b0, jump_height}) begin
                        if (jump_sum < {1'b0, motion_pkg::JUMP_MAX_PERIOD}) begin
                            jump_per_nxt = jump_sum[19:0];
                        end else if (jump_per < motion_pkg::JUMP_MAX_PERIOD) begin
                            jump_per_nxt = motion_pkg::JUMP_MAX_PERIOD;
                        end
                    end
                end else begin
                    cnt_y_nxt = cnt_y + 20'd1;
                end
            end

            motion_pkg::FALLING: begin
                jump_per_nxt = jump_period;
                if (on_ground) begin
                    state_nxt = motion_pkg::IDLE;
                    cnt_y_nxt = '0;
                end else if (cnt_y >= fall_per) begin
                    y_nxt     = host_y + 10'd1;
                    cnt_y_nxt = '0;
                    if ({1'b0, fall_per} > fall_floor) begin
                        fall_per_nxt = fall_per - grav_step;   // speeds up each pixel
                    end else if (fall_per > motion_pkg::FALL_MIN_PERIOD) begin
                        fall_per_nxt = motion_pkg::FALL_MIN_PERIOD;
                    end
                end else begin
                    cnt_y_nxt = cnt_y + 20'd1;
                end
            end

            default: begin
                state_nxt = motion_pkg::IDLE;
            end
        endcase

        sprite_nxt = {face_nxt,
                      (state_nxt == motion_pkg::JUMPING) || (state_nxt == motion_pkg::FALLING),
                      state_nxt == motion_pkg::IDLE,
                      1'b0,
                      frame_nxt};

        // restart and game over only act on a host at rest
        if (state == motion_pkg::IDLE && (restart || over != 2'b00)) begin
            state_nxt  = motion_pkg::IDLE;
            x_nxt      = game_geom_pkg::SPAWN_X;
            y_nxt      = game_geom_pkg::SPAWN_Y;
            cnt_x_nxt  = '0;
            px_cnt_nxt = '0;
            sprite_nxt = motion_pkg::SPRITE_RESET;
        end
    end

endmodule

// File: logic/platform_collide.sv
// combinational only; platforms are one row thick for landing and solid when hit from below
`timescale 1ns/1ns

module platform_collide (
    input  game_geom_pkg::coord_t cand_x,
    input  game_geom_pkg::coord_t cand_y,
    output logic                  on_ground,
    output logic                  head_hit
);

    localparam int N = game_geom_pkg::NUM_PLATFORMS;

    // one extra bit so the box edges never wrap
    logic [10:0] box_left;
    logic [10:0] box_right;
    logic [10:0] box_top;
    logic [10:0] box_foot;

    logic [N-1:0] x_overlap;
    logic [N-1:0] land;
    logic [N-1:0] bump;
    logic         on_floor;

    assign box_left  = {1'b0, cand_x};
    assign box_right = box_left + 11'(game_geom_pkg::HOST_W - 1);
    assign box_top   = {1'b0, cand_y};
    assign box_foot  = box_top + 11'(game_geom_pkg::HOST_H);   // row just under the feet

    assign on_floor = (box_foot == 11'(game_geom_pkg::FLOOR_Y));

    always_comb begin
        for (int i = 0; i < N; i++) begin
            // any shared column counts
            x_overlap[i] = (box_left <= {1'b0, game_geom_pkg::PLAT_X1[i]}) &&
                           (box_right >= {1'b0, game_geom_pkg::PLAT_X0[i]});

            land[i] = x_overlap[i] && (box_foot == {1'b0, game_geom_pkg::PLAT_Y[i]});

            // head one row under the platform
            bump[i] = x_overlap[i] &&
                      (box_top == {1'b0, game_geom_pkg::PLAT_Y[i]} + 11'd1);
        end
    end

    assign on_ground = on_floor || (|land);
    assign head_hit  = |bump;

endmodule

// File: logic/motion_cfg_regs.sv
// writes land on the edge with we high and are visible next cycle; unused addresses are dropped
`timescale 1ns/1ns

module motion_cfg_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  we,
    input  motion_pkg::cfg_addr_t addr,
    input  motion_pkg::period_t   wdata,

    output motion_pkg::period_t   walk_period,
    output motion_pkg::period_t   air_period,
    output motion_pkg::period_t   jump_period,
    output motion_pkg::period_t   fall_period,
    output motion_pkg::period_t   grav_step,
    output game_geom_pkg::coord_t jump_height
);

    always_ff @(posedge clk) begin
        if (rst) begin
            walk_period <= motion_pkg::DEF_WALK;
            air_period  <= motion_pkg::DEF_AIR;
            jump_period <= motion_pkg::DEF_JUMP;
            fall_period <= motion_pkg::DEF_FALL;
            grav_step   <= motion_pkg::DEF_GRAV;
            jump_height <= game_geom_pkg::coord_t'(motion_pkg::DEF_JUMP_H);
        end else if (we) begin
            case (addr)
                motion_pkg::CFG_WALK: begin
                    walk_period <= wdata;
                end
                motion_pkg::CFG_AIR: begin
                    air_period <= wdata;
                end
                motion_pkg::CFG_JUMP: begin
                    jump_period <= wdata;   // start of every rise
                end
                motion_pkg::CFG_FALL: begin
                    fall_period <= wdata;   // start of every fall
                end
                motion_pkg::CFG_GRAV: begin
                    grav_step <= wdata;
                end
                motion_pkg::CFG_JUMP_H: begin
                    jump_height <= wdata[9:0];
                end
                default: begin
                    // addresses 6 and 7 have no register
                end
            endcase
        end
    end

endmodule

// File: logic/motion_pkg.sv
// periods are in clk cycles per pixel minus one; hardware defaults assume a 100 MHz clock
package motion_pkg;

    typedef enum logic [1:0] {
        IDLE    = 2'b00,
        MOVING  = 2'b01,
        JUMPING = 2'b11,
        FALLING = 2'b10
    } move_state_t;

    typedef logic [19:0] period_t;

    // {facing right, airborne, idle, frame[3:0]}
    typedef logic [6:0] sprite_ctrl_t;

    typedef logic [2:0] cfg_addr_t;

    localparam cfg_addr_t CFG_WALK   = 3'd0;
    localparam cfg_addr_t CFG_AIR    = 3'd1;
    localparam cfg_addr_t CFG_JUMP   = 3'd2;
    localparam cfg_addr_t CFG_FALL   = 3'd3;
    localparam cfg_addr_t CFG_GRAV   = 3'd4;
    localparam cfg_addr_t CFG_JUMP_H = 3'd5;   // only low 10 bits kept

    localparam period_t DEF_WALK   = 20'd425_000;
    localparam period_t DEF_AIR    = 20'd600_000;
    localparam period_t DEF_JUMP   = 20'd200_000;
    localparam period_t DEF_FALL   = 20'd800_000;
    localparam period_t DEF_GRAV   = 20'd20_000;
    localparam period_t DEF_JUMP_H = 20'd200;

    // bounds for the gravity ramps
    localparam period_t FALL_MIN_PERIOD = 20'd150_000;
    localparam period_t JUMP_MAX_PERIOD = 20'd800_000;

    localparam sprite_ctrl_t SPRITE_RESET = 7'b101_0000;   // facing right, idle, frame 0

endpackage

// File: logic/game_geom_pkg.sv
// screen coordinates are top-left based, 10 bits per axis; platforms stay clear of the spawn column
package game_geom_pkg;

    typedef logic [9:0] coord_t;   // one screen axis, x or y

    localparam int SCREEN_W = 1024;
    localparam int SCREEN_H = 768;

    localparam int HOST_W = 48;
    localparam int HOST_H = 64;

    localparam int FLOOR_Y = SCREEN_H - 1;   // floor surface row

    // host rests when y + HOST_H hits a surface row
    localparam coord_t SPAWN_X = 10'd500;
    localparam coord_t SPAWN_Y = coord_t'(FLOOR_Y - HOST_H);

    localparam int NUM_PLATFORMS = 5;

    // entry 0 is the lowest platform
    localparam coord_t PLAT_X0 [NUM_PLATFORMS] = '{
        10'd100, 10'd640, 10'd240, 10'd700, 10'd60
    };

    localparam coord_t PLAT_X1 [NUM_PLATFORMS] = '{
        10'd299, 10'd879, 10'd459, 10'd899, 10'd219
    };

    // top row, the landing surface
    localparam coord_t PLAT_Y [NUM_PLATFORMS] = '{
        10'd620, 10'd560, 10'd470, 10'd400, 10'd320
    };

endpackage
